// File: Bender.yml
package:
  name: tinker_core

sources:
  - common/tinker_pkg.sv
  - common/exec_if.sv
  - hw/front/instr_front.sv
  - hw/front/reg_file.sv
  - hw/execute/exec_unit.sv
  - hw/sequencer.sv
  - hw/mem_port.sv
  - hw/tinker_core.sv
  - target: simulation
    files:
      - verif/tb_checker.sv
      - verif/tb_tinker.sv

// File: common/exec_if.sv
// Decoded operands from front end to execute unit; values hold from decode until the next fetch
`timescale 1ns/1ps

interface exec_if;

    tinker_pkg::opcode_t opcode;
    tinker_pkg::word_t   pc;
    tinker_pkg::word_t   imm;     // Sign-extended immediate
    tinker_pkg::word_t   rd_val;
    tinker_pkg::word_t   rs_val;  // rd for immediate forms
    tinker_pkg::word_t   rt_val;

    modport front (
        output opcode, pc, imm, rd_val, rs_val, rt_val
    );

    modport exec (
        input opcode, pc, imm, rd_val, rs_val, rt_val
    );

endinterface

// File: common/tinker_pkg.sv
// Tinker widths, opcodes and state encodings; multiply, divide, call and return are not supported
package tinker_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int word_bits = 64;
    localparam int imm_bits  = 12;

    typedef logic [word_bits-1:0] word_t;     // Data, address, register value
    typedef logic [31:0]          instr_t;    // Instruction word
    typedef logic [4:0]           reg_addr_t; // Register number
    typedef logic [4:0]           opcode_t;   // Opcode field
    typedef logic [imm_bits-1:0]  imm_t;      // Raw immediate field

    typedef enum logic [2:0] {
        st_fetch, st_decode, st_execute, st_memory, st_writeback, st_halted
    } state_e;

    localparam word_t reset_pc    = 64'h2000;
    localparam word_t instr_bytes = 64'd4;    // PC step

    // Field positions, lsb of each field
    localparam int op_pos  = 27;
    localparam int rd_pos  = 22;
    localparam int rs_pos  = 17;
    localparam int rt_pos  = 12;
    localparam int imm_pos = 0;

    // ----------------------------------------
    // Opcodes
    // ----------------------------------------
    localparam opcode_t op_and    = 5'h00;
    localparam opcode_t op_or     = 5'h01;
    localparam opcode_t op_xor    = 5'h02;
    localparam opcode_t op_not    = 5'h03;
    localparam opcode_t op_shftr  = 5'h04;
    localparam opcode_t op_shftri = 5'h05;
    localparam opcode_t op_shftl  = 5'h06;
    localparam opcode_t op_shftli = 5'h07;
    localparam opcode_t op_br     = 5'h08;
    localparam opcode_t op_brr_r  = 5'h09;
    localparam opcode_t op_brr_l  = 5'h0a;
    localparam opcode_t op_brnz   = 5'h0b;
    localparam opcode_t op_brgt   = 5'h0e;
    localparam opcode_t op_load   = 5'h10;
    localparam opcode_t op_mov_r  = 5'h11;
    localparam opcode_t op_mov_l  = 5'h12;
    localparam opcode_t op_store  = 5'h13;
    localparam opcode_t op_add    = 5'h18;
    localparam opcode_t op_addi   = 5'h19;
    localparam opcode_t op_sub    = 5'h1a;
    localparam opcode_t op_subi   = 5'h1b;
    localparam opcode_t op_halt   = 5'h1f;

    // ----------------------------------------
    // Opcode classes
    // ----------------------------------------
    function automatic logic is_load(opcode_t op);
        return op == op_load;
    endfunction

    function automatic logic is_store(opcode_t op);
        return op == op_store;
    endfunction

    function automatic logic is_mem_op(opcode_t op);
        return is_load(op) || is_store(op);
    endfunction

    function automatic logic is_branch(opcode_t op);
        return op inside {op_br, op_brr_r, op_brr_l, op_brnz, op_brgt};
    endfunction

    // Immediate forms take the literal as second operand
    function automatic logic uses_literal(opcode_t op);
        return op inside {op_addi, op_subi, op_shftri, op_shftli, op_mov_l};
    endfunction

    // Same set: rd is both source and destination
    function automatic logic rd_as_src(opcode_t op);
        return uses_literal(op);
    endfunction

    function automatic logic writes_reg(opcode_t op);
        return !is_store(op) && !is_branch(op) && op != op_halt;
    endfunction

endpackage

// File: files.f
common/tinker_pkg.sv
common/exec_if.sv
hw/front/instr_front.sv
hw/front/reg_file.sv
hw/execute/exec_unit.sv
hw/sequencer.sv
hw/mem_port.sv
hw/tinker_core.sv
verif/tb_checker.sv
verif/tb_tinker.sv

// File: hw/execute/exec_unit.sv
// ALU, branch target and memory address; shifts are logical and use the full second operand
`timescale 1ns/1ps

module exec_unit (
    input  logic              clk,
    input  logic              reset,
    exec_if.exec              ops,
    input  logic              alu_latch,
    output tinker_pkg::word_t alu_result,
    output tinker_pkg::word_t next_pc,
    output tinker_pkg::word_t mem_addr_calc,
    output tinker_pkg::word_t store_data
);

    tinker_pkg::word_t in1, in2, alu_out, pc_plus4;

    // ----------------------------------------
    // ALU
    // ----------------------------------------
    assign in1 = ops.rs_val;                                        // rd for immediate forms
    assign in2 = tinker_pkg::uses_literal(ops.opcode) ? ops.imm : ops.rt_val;

    always_comb begin
        case (ops.opcode)
            tinker_pkg::op_add,
            tinker_pkg::op_addi:   alu_out = in1 + in2;
            tinker_pkg::op_sub,
            tinker_pkg::op_subi:   alu_out = in1 - in2;
            tinker_pkg::op_and:    alu_out = in1 & in2;
            tinker_pkg::op_or:     alu_out = in1 | in2;
            tinker_pkg::op_xor:    alu_out = in1 ^ in2;
            tinker_pkg::op_not:    alu_out = ~in1;
            tinker_pkg::op_shftr,
            tinker_pkg::op_shftri: alu_out = in1 >> in2;
            tinker_pkg::op_shftl,
            tinker_pkg::op_shftli: alu_out = in1 << in2;
            tinker_pkg::op_mov_r:  alu_out = in1;
            tinker_pkg::op_mov_l:  alu_out = {in2[11:0], in1[51:0]};  // Literal into top 12 bits
            default:               alu_out = '0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            alu_result <= '0;
        else if (alu_latch)
            alu_result <= alu_out;
    end

    // ----------------------------------------
    // Branch resolution
    // ----------------------------------------
    assign pc_plus4 = ops.pc + tinker_pkg::instr_bytes;

    always_comb begin
        case (ops.opcode)
            tinker_pkg::op_br:    next_pc = ops.rd_val;
            tinker_pkg::op_brr_r: next_pc = ops.pc + ops.rd_val;
            tinker_pkg::op_brr_l: next_pc = ops.pc + ops.imm;
            tinker_pkg::op_brnz:
                next_pc = (ops.rs_val != '0) ? ops.rd_val : pc_plus4;
            tinker_pkg::op_brgt:
                next_pc = ($signed(ops.rs_val) > $signed(ops.rt_val)) ? ops.rd_val : pc_plus4;
            default:              next_pc = pc_plus4;    // Sequential flow
        endcase
    end

    // ----------------------------------------
    // Memory address and store data
    // ----------------------------------------
    assign mem_addr_calc = tinker_pkg::is_load(ops.opcode) ? ops.rs_val + ops.imm   // load rd, (rs)L
                                                           : ops.rd_val + ops.imm;  // store (rd)L, rs
    assign store_data    = ops.rs_val;

endmodule

// File: hw/front/instr_front.sv
// PC and instruction register with field decode; immediate forms read rd as first source
`timescale 1ns/1ps

module instr_front (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  ir_load,
    input  logic                  pc_write,
    input  tinker_pkg::word_t     fetch_data,
    input  tinker_pkg::word_t     next_pc,
    output tinker_pkg::reg_addr_t rf_addr1,
    output tinker_pkg::reg_addr_t rf_addr2,
    output tinker_pkg::reg_addr_t rf_addr_d,
    input  tinker_pkg::word_t     rf_data1,
    input  tinker_pkg::word_t     rf_data2,
    input  tinker_pkg::word_t     rf_data_d,
    exec_if.front                 dec,
    output tinker_pkg::reg_addr_t wb_addr,
    output tinker_pkg::opcode_t   opcode
);

    tinker_pkg::word_t     pc_q;
    tinker_pkg::instr_t    ir_q;
    tinker_pkg::opcode_t   op;
    tinker_pkg::reg_addr_t rd, rs, rt;
    tinker_pkg::imm_t      imm_raw;

    // ----------------------------------------
    // PC and IR
    // ----------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc_q <= tinker_pkg::reset_pc;
            ir_q <= '0;
        end else begin
            if (pc_write)
                pc_q <= next_pc;
            if (ir_load)
                ir_q <= fetch_data[31:0];     // Low word holds the instruction
        end
    end

    // ----------------------------------------
    // Field decode
    // ----------------------------------------
    assign op      = ir_q[tinker_pkg::op_pos +: 5];
    assign rd      = ir_q[tinker_pkg::rd_pos +: 5];
    assign rs      = ir_q[tinker_pkg::rs_pos +: 5];
    assign rt      = ir_q[tinker_pkg::rt_pos +: 5];
    assign imm_raw = ir_q[tinker_pkg::imm_pos +: tinker_pkg::imm_bits];

    assign rf_addr1  = tinker_pkg::rd_as_src(op) ? rd : rs;  // addi rd, L reads rd
    assign rf_addr2  = rt;
    assign rf_addr_d = rd;
    assign wb_addr   = rd;                                   // Destination is always rd
    assign opcode    = op;

    // Operands to execute
    assign dec.opcode = op;
    assign dec.pc     = pc_q;
    assign dec.imm    = {{(tinker_pkg::word_bits - tinker_pkg::imm_bits){imm_raw[11]}}, imm_raw};
    assign dec.rd_val = rf_data_d;
    assign dec.rs_val = rf_data1;
    assign dec.rt_val = rf_data2;

endmodule

// File: hw/front/reg_file.sv
// 32 x 64-bit registers, r0 not hardwired; reads are combinational, rdata_d follows waddr
`timescale 1ns/1ps

module reg_file (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  we,
    input  tinker_pkg::reg_addr_t waddr,
    input  tinker_pkg::reg_addr_t raddr1,
    input  tinker_pkg::reg_addr_t raddr2,
    input  tinker_pkg::word_t     wdata,
    output tinker_pkg::word_t     rdata1,
    output tinker_pkg::word_t     rdata2,
    output tinker_pkg::word_t     rdata_d
);

    tinker_pkg::word_t regs [32];

    assign rdata1  = regs[raddr1];
    assign rdata2  = regs[raddr2];
    assign rdata_d = regs[waddr];   // rd operand for branches and stores

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // Writeback address comes from the IR, which must be loaded by then
    a_waddr_known: assert property (@(posedge clk) disable iff (reset)
        we |-> !$isunknown(waddr));

endmodule

// File: hw/mem_port.sv
// Memory port; address from PC in fetch, else computed, with the load data register
`timescale 1ns/1ps

module mem_port (
    input  logic              clk,
    input  logic              reset,
    input  logic              sel_fetch,
    input  logic              rd,
    input  logic              wr,
    input  logic              mdr_load,
    input  logic              wb_from_mem,
    input  tinker_pkg::word_t pc,
    input  tinker_pkg::word_t mem_addr_calc,
    input  tinker_pkg::word_t store_data,
    input  tinker_pkg::word_t alu_result,
    input  tinker_pkg::word_t mem_rdata,
    output tinker_pkg::word_t mem_addr,
    output tinker_pkg::word_t mem_wdata,
    output tinker_pkg::word_t wb_data,
    output tinker_pkg::word_t fetch_data,
    output logic              mem_rd,
    output logic              mem_wr
);

    tinker_pkg::word_t mdr_q;

    assign mem_addr   = sel_fetch ? pc : mem_addr_calc;
    assign mem_rd     = rd & ~reset;              // Quiet while reset is held
    assign mem_wr     = wr;
    assign mem_wdata  = store_data;
    assign fetch_data = mem_rdata;

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            mdr_q <= '0;
        else if (mdr_load)                        // Memory-cycle load only
            mdr_q <= mem_rdata;
    end

    assign wb_data = wb_from_mem ? mdr_q : alu_result;

endmodule

// File: hw/sequencer.sv
// Instruction FSM; branch 3, ALU and mov 4, load and store 5 cycles, halt holds until reset
`timescale 1ns/1ps

module sequencer (
    input  logic                clk,
    input  logic                reset,
    input  tinker_pkg::opcode_t opcode,
    output logic                ir_load,
    output logic                pc_write,
    output logic                alu_latch,
    output logic                sel_fetch,
    output logic                mem_rd,
    output logic                mem_wr,
    output logic                mdr_load,
    output logic                reg_write,
    output logic                wb_from_mem,
    output logic                hlt
);

    tinker_pkg::state_e state_q, state_d;

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            state_q <= tinker_pkg::st_fetch;
        else
            state_q <= state_d;
    end

    // ----------------------------------------
    // Next state and strobes
    // ----------------------------------------
    always_comb begin
        state_d     = state_q;
        ir_load     = 1'b0;
        pc_write    = 1'b0;
        alu_latch   = 1'b0;
        sel_fetch   = 1'b0;
        mem_rd      = 1'b0;
        mem_wr      = 1'b0;
        mdr_load    = 1'b0;
        reg_write   = 1'b0;
        wb_from_mem = 1'b0;
        hlt         = 1'b0;
        case (state_q)
            tinker_pkg::st_fetch: begin
                ir_load   = 1'b1;
                mem_rd    = 1'b1;
                sel_fetch = 1'b1;                    // Address from PC
                state_d   = tinker_pkg::st_decode;
            end
            tinker_pkg::st_decode: begin
                state_d = (opcode == tinker_pkg::op_halt) ? tinker_pkg::st_halted
                                                          : tinker_pkg::st_execute;
            end
            tinker_pkg::st_execute: begin
                alu_latch = 1'b1;
                if (tinker_pkg::is_branch(opcode)) begin
                    pc_write = 1'b1;                 // Target or PC+4
                    state_d  = tinker_pkg::st_fetch;
                end else if (tinker_pkg::is_mem_op(opcode)) begin
                    state_d = tinker_pkg::st_memory;
                end else begin
                    state_d = tinker_pkg::st_writeback;
                end
            end
            tinker_pkg::st_memory: begin
                mem_rd   = tinker_pkg::is_load(opcode);
                mem_wr   = tinker_pkg::is_store(opcode);
                mdr_load = tinker_pkg::is_load(opcode);
                state_d  = tinker_pkg::st_writeback;
            end
            tinker_pkg::st_writeback: begin
                reg_write   = tinker_pkg::writes_reg(opcode);
                wb_from_mem = tinker_pkg::is_load(opcode);
                pc_write    = 1'b1;                  // PC+4
                state_d     = tinker_pkg::st_fetch;
            end
            tinker_pkg::st_halted: hlt = 1'b1;       // Stays until reset
            default: state_d = tinker_pkg::st_fetch;
        endcase
    end

    a_one_strobe: assert property (@(posedge clk) disable iff (reset)
        !(mem_rd && mem_wr));

    a_hlt_sticky: assert property (@(posedge clk) disable iff (reset)
        hlt |=> hlt);

endmodule

// File: hw/tinker_core.sv
// Tinker multi-cycle core; external memory must answer reads combinationally in the same cycle
`timescale 1ns/1ps

module tinker_core (
    input  logic              clk,
    input  logic              reset,
    output tinker_pkg::word_t mem_addr,
    output tinker_pkg::word_t mem_wdata,
    output logic              mem_rd,
    output logic              mem_wr,
    input  tinker_pkg::word_t mem_rdata,
    output logic              hlt
);

    // ----------------------------------------
    // Control strobes
    // ----------------------------------------
    logic ir_load, pc_write, alu_latch, sel_fetch;
    logic seq_rd, seq_wr, mdr_load, reg_write, wb_from_mem;

    // ----------------------------------------
    // Datapath wires
    // ----------------------------------------
    tinker_pkg::word_t     fetch_data, next_pc, wb_data;
    tinker_pkg::word_t     rf_data1, rf_data2, rf_data_d;
    tinker_pkg::word_t     alu_result, mem_addr_calc, store_data;
    tinker_pkg::reg_addr_t rf_addr1, rf_addr2, wb_addr;
    tinker_pkg::opcode_t   opcode;

    exec_if dec_bus ();

    instr_front i_instr_front (
        .clk        (clk),
        .reset      (reset),
        .ir_load    (ir_load),
        .pc_write   (pc_write),
        .fetch_data (fetch_data),
        .next_pc    (next_pc),
        .rf_addr1   (rf_addr1),
        .rf_addr2   (rf_addr2),
        .rf_addr_d  (),            // Same field as wb_addr
        .rf_data1   (rf_data1),
        .rf_data2   (rf_data2),
        .rf_data_d  (rf_data_d),
        .dec        (dec_bus.front),
        .wb_addr    (wb_addr),
        .opcode     (opcode)
    );

    reg_file i_reg_file (
        .clk     (clk),
        .reset   (reset),
        .we      (reg_write),
        .waddr   (wb_addr),
        .raddr1  (rf_addr1),
        .raddr2  (rf_addr2),
        .wdata   (wb_data),
        .rdata1  (rf_data1),
        .rdata2  (rf_data2),
        .rdata_d (rf_data_d)
    );

    exec_unit i_exec_unit (
        .clk           (clk),
        .reset         (reset),
        .ops           (dec_bus.exec),
        .alu_latch     (alu_latch),
        .alu_result    (alu_result),
        .next_pc       (next_pc),
        .mem_addr_calc (mem_addr_calc),
        .store_data    (store_data)
    );

    sequencer i_sequencer (
        .clk         (clk),
        .reset       (reset),
        .opcode      (opcode),
        .ir_load     (ir_load),
        .pc_write    (pc_write),
        .alu_latch   (alu_latch),
        .sel_fetch   (sel_fetch),
        .mem_rd      (seq_rd),
        .mem_wr      (seq_wr),
        .mdr_load    (mdr_load),
        .reg_write   (reg_write),
        .wb_from_mem (wb_from_mem),
        .hlt         (hlt)
    );

    mem_port i_mem_port (
        .clk           (clk),
        .reset         (reset),
        .sel_fetch     (sel_fetch),
        .rd            (seq_rd),
        .wr            (seq_wr),
        .mdr_load      (mdr_load),
        .wb_from_mem   (wb_from_mem),
        .pc            (dec_bus.pc),
        .mem_addr_calc (mem_addr_calc),
        .store_data    (store_data),
        .alu_result    (alu_result),
        .mem_rdata     (mem_rdata),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .wb_data       (wb_data),
        .fetch_data    (fetch_data),
        .mem_rd        (mem_rd),
        .mem_wr        (mem_wr)
    );

endmodule

// File: verif/tb_checker.sv
// Instruction-set model of the core; samples the memory port on falling edges, 64 KiB image
`timescale 1ns/1ps

module tb_checker (
    input  logic              clk,
    input  logic              reset,
    input  tinker_pkg::word_t mem_addr,
    input  tinker_pkg::word_t mem_wdata,
    input  logic              mem_rd,
    input  logic              mem_wr,
    input  logic              hlt,
    output int                error_count,
    output int                check_count
);

    logic [7:0]        model_mem [0:65535];   // Copy of the testbench memory
    tinker_pkg::word_t regs [32];
    tinker_pkg::word_t pc;
    logic              halted;                // Model has fetched halt
    logic              hlt_seen;

    // Expected accesses in order
    logic              exp_wr [$];
    tinker_pkg::word_t exp_addr [$];
    tinker_pkg::word_t exp_data [$];

    initial begin
        error_count = 0;
        check_count = 0;
    end

    task automatic load_byte(input logic [15:0] addr, input logic [7:0] value);
        model_mem[addr] = value;
    endtask

    function automatic tinker_pkg::word_t read_word(tinker_pkg::word_t addr);
        tinker_pkg::word_t w;
        for (int b = 0; b < 8; b++)
            w[8*b +: 8] = model_mem[16'(addr[15:0] + b)];   // Little-endian
        return w;
    endfunction

    task automatic write_word(tinker_pkg::word_t addr, tinker_pkg::word_t w);
        for (int b = 0; b < 8; b++)
            model_mem[16'(addr[15:0] + b)] = w[8*b +: 8];
    endtask

    task automatic push_access(logic wr, tinker_pkg::word_t addr, tinker_pkg::word_t data);
        exp_wr.push_back(wr);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic report_failure(string msg);
        error_count = error_count + 1;
        $display("%s", msg);
    endtask

    task automatic compare_value(string name, tinker_pkg::word_t got, tinker_pkg::word_t exp);
        check_count = check_count + 1;
        if (got !== exp) begin
            error_count = error_count + 1;
            $display("error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // ----------------------------------------
    // ISA rules
    // ----------------------------------------
    function automatic tinker_pkg::word_t alu_model(tinker_pkg::opcode_t op,
            input tinker_pkg::word_t rd_v, rs_v, rt_v, imm);
        case (op)
            tinker_pkg::op_add:    return rs_v + rt_v;
            tinker_pkg::op_addi:   return rd_v + imm;      // Immediate forms work on rd
            tinker_pkg::op_sub:    return rs_v - rt_v;
            tinker_pkg::op_subi:   return rd_v - imm;
            tinker_pkg::op_and:    return rs_v & rt_v;
            tinker_pkg::op_or:     return rs_v | rt_v;
            tinker_pkg::op_xor:    return rs_v ^ rt_v;
            tinker_pkg::op_not:    return ~rs_v;
            tinker_pkg::op_shftr:  return (rt_v > 63) ? '0 : rs_v >> rt_v[5:0];
            tinker_pkg::op_shftri: return (imm > 63) ? '0 : rd_v >> imm[5:0];
            tinker_pkg::op_shftl:  return (rt_v > 63) ? '0 : rs_v << rt_v[5:0];
            tinker_pkg::op_shftli: return (imm > 63) ? '0 : rd_v << imm[5:0];
            tinker_pkg::op_mov_r:  return rs_v;
            tinker_pkg::op_mov_l:  return (rd_v & {12'h000, {52{1'b1}}}) | (imm << 52);
            default:               return '0;
        endcase
    endfunction

    // Runs one instruction and queues its accesses
    task automatic step_model();
        tinker_pkg::word_t   fetched, imm, addr, next_pc;
        tinker_pkg::opcode_t op;
        logic [4:0]          rd, rs, rt;
        fetched = read_word(pc);
        push_access(1'b0, pc, '0);
        op      = fetched[31:27];
        rd      = fetched[26:22];
        rs      = fetched[21:17];
        rt      = fetched[16:12];
        imm     = {{52{fetched[11]}}, fetched[11:0]};
        next_pc = pc + 4;
        case (op)
            tinker_pkg::op_halt:  halted = 1'b1;
            tinker_pkg::op_load: begin
                addr = regs[rs] + imm;
                push_access(1'b0, addr, '0);
                regs[rd] = read_word(addr);
            end
            tinker_pkg::op_store: begin
                addr = regs[rd] + imm;
                push_access(1'b1, addr, regs[rs]);
                write_word(addr, regs[rs]);
            end
            tinker_pkg::op_br:    next_pc = regs[rd];
            tinker_pkg::op_brr_r: next_pc = pc + regs[rd];
            tinker_pkg::op_brr_l: next_pc = pc + imm;
            tinker_pkg::op_brnz:
                if (regs[rs] != '0)
                    next_pc = regs[rd];
            tinker_pkg::op_brgt:
                if ($signed(regs[rs]) > $signed(regs[rt]))
                    next_pc = regs[rd];
            default: regs[rd] = alu_model(op, regs[rd], regs[rs], regs[rt], imm);
        endcase
        pc = next_pc;
    endtask

    task automatic check_access();
        logic              wr;
        tinker_pkg::word_t addr, data;
        if (exp_addr.size() == 0 && !halted)
            step_model();
        if (exp_addr.size() == 0) begin
            report_failure($sformatf("memory access after halt at address %h", mem_addr));
        end else begin
            wr   = exp_wr.pop_front();
            addr = exp_addr.pop_front();
            data = exp_data.pop_front();
            compare_value("mem_wr", mem_wr, wr);
            compare_value("mem_rd", mem_rd, !wr);
            compare_value("mem_addr", mem_addr, addr);
            if (wr)
                compare_value("mem_wdata", mem_wdata, data);
        end
    endtask

    // ----------------------------------------
    // Port monitor
    // ----------------------------------------
    always @(negedge clk) begin
        if (reset) begin
            pc       = tinker_pkg::reset_pc;
            halted   = 1'b0;
            hlt_seen = 1'b0;
            for (int i = 0; i < 32; i++)
                regs[i] = '0;
            exp_wr.delete();
            exp_addr.delete();
            exp_data.delete();
            if (hlt !== 1'b0 || mem_rd !== 1'b0 || mem_wr !== 1'b0)
                report_failure("hlt, mem_rd or mem_wr is high during reset");
        end else begin
            if ($isunknown({mem_rd, mem_wr, hlt}))
                report_failure("unknown value on mem_rd, mem_wr or hlt");
            if (mem_rd === 1'b1 || mem_wr === 1'b1)
                check_access();
            if (hlt === 1'b1) begin
                if (!hlt_seen && (!halted || exp_addr.size() != 0))
                    report_failure("hlt rose before the halt instruction was reached");
                hlt_seen = 1'b1;
            end else if (hlt_seen) begin
                report_failure("hlt fell after halt without a reset");
                hlt_seen = 1'b0;                      // Report once
            end
        end
    end

endmodule

// File: verif/tb_tinker.sv
// Testbench top; random program at 0x2000, 64 KiB byte memory that wraps, data window at 0x8000
`timescale 1ns/1ps

module tb_tinker;

    logic              clk;
    logic              reset;
    tinker_pkg::word_t mem_addr, mem_wdata, mem_rdata;
    logic              mem_rd, mem_wr, hlt;
    int                error_count, check_count;

    logic [7:0]        mem [0:65535];   // Byte memory
    tinker_pkg::word_t wp;              // Next program address
    int                n_instr;
    int                seed;
    int                limit;           // Watchdog cycles

    tinker_core i_tinker_core (
        .clk       (clk),
        .reset     (reset),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rd    (mem_rd),
        .mem_wr    (mem_wr),
        .mem_rdata (mem_rdata),
        .hlt       (hlt)
    );

    tb_checker i_checker (
        .clk         (clk),
        .reset       (reset),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_rd      (mem_rd),
        .mem_wr      (mem_wr),
        .hlt         (hlt),
        .error_count (error_count),
        .check_count (check_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;          // 4 ns period
    end

    // ----------------------------------------
    // Memory model
    // ----------------------------------------
    for (genvar i = 0; i < 8; i++) begin : g_rdata
        assign mem_rdata[8*i +: 8] = mem[16'(mem_addr[15:0] + i)];   // Same-cycle read
    end

    always @(posedge clk) begin
        if (mem_wr === 1'b1) begin
            for (int b = 0; b < 8; b++)
                mem[16'(mem_addr[15:0] + b)] <= mem_wdata[8*b +: 8];   // Little-endian
        end
    end

    // ----------------------------------------
    // Program generator
    // ----------------------------------------
    function automatic tinker_pkg::instr_t encode(tinker_pkg::opcode_t op, logic [4:0] rd,
            logic [4:0] rs, logic [4:0] rt, logic [11:0] imm);
        return {op, rd, rs, rt, imm};
    endfunction

    function automatic tinker_pkg::opcode_t alu_op(int k);
        case (k)
            0:       return tinker_pkg::op_and;
            1:       return tinker_pkg::op_or;
            2:       return tinker_pkg::op_xor;
            3:       return tinker_pkg::op_not;
            4:       return tinker_pkg::op_shftr;
            5:       return tinker_pkg::op_shftri;
            6:       return tinker_pkg::op_shftl;
            7:       return tinker_pkg::op_shftli;
            8:       return tinker_pkg::op_mov_r;
            9:       return tinker_pkg::op_mov_l;
            10:      return tinker_pkg::op_add;
            11:      return tinker_pkg::op_addi;
            12:      return tinker_pkg::op_sub;
            default: return tinker_pkg::op_subi;
        endcase
    endfunction

    task automatic put_instr(tinker_pkg::instr_t ins);
        for (int b = 0; b < 4; b++)
            mem[16'(wp[15:0] + b)] = ins[8*b +: 8];
        wp      = wp + 4;
        n_instr = n_instr + 1;
    endtask

    // Destinations stay below r28, which holds the code base
    task automatic emit_alu();
        tinker_pkg::opcode_t op;
        logic [11:0]         imm;
        op = alu_op($urandom_range(0, 13));
        if (op == tinker_pkg::op_shftri || op == tinker_pkg::op_shftli)
            imm = 12'($urandom_range(0, 63));
        else
            imm = 12'($urandom);
        put_instr(encode(op, 5'($urandom_range(0, 27)), 5'($urandom_range(0, 31)),
                         5'($urandom_range(0, 31)), imm));
    endtask

    task automatic emit_branch();
        int                kind;
        int                skip;
        logic [4:0]        ra, rb;
        tinker_pkg::word_t br_pc, tgt;
        kind = $urandom_range(0, 4);
        skip = $urandom_range(1, 3);
        ra   = 5'($urandom_range(0, 27));
        rb   = 5'($urandom_range(0, 27));
        if (kind == 3 && $urandom_range(0, 2) == 0)
            put_instr(encode(tinker_pkg::op_xor, ra, ra, ra, 12'd0));   // brnz falls through
        br_pc = wp + ((kind == 2) ? 0 : 8);                // After two setup instructions
        tgt   = br_pc + 4 * (skip + 1);                    // Just past the fillers
        if (kind == 1) begin
            put_instr(encode(tinker_pkg::op_xor, 5'd29, 5'd29, 5'd29, 12'd0));
            put_instr(encode(tinker_pkg::op_addi, 5'd29, 5'd0, 5'd0, 12'(tgt - br_pc)));
        end else if (kind != 2) begin
            put_instr(encode(tinker_pkg::op_mov_r, 5'd29, 5'd28, 5'd0, 12'd0));
            put_instr(encode(tinker_pkg::op_addi, 5'd29, 5'd0, 5'd0,
                             12'(tgt - tinker_pkg::reset_pc)));
        end
        case (kind)
            0:       put_instr(encode(tinker_pkg::op_br, 5'd29, 5'd0, 5'd0, 12'd0));
            1:       put_instr(encode(tinker_pkg::op_brr_r, 5'd29, 5'd0, 5'd0, 12'd0));
            2:       put_instr(encode(tinker_pkg::op_brr_l, 5'd0, 5'd0, 5'd0, 12'(tgt - br_pc)));
            3:       put_instr(encode(tinker_pkg::op_brnz, 5'd29, ra, 5'd0, 12'd0));
            default: put_instr(encode(tinker_pkg::op_brgt, 5'd29, ra, rb, 12'd0));
        endcase
        for (int i = 0; i < skip; i++)
            emit_alu();
    endtask

    task automatic build_program();
        int          kind;
        logic [11:0] offs;
        wp      = tinker_pkg::reset_pc;
        n_instr = 0;
        put_instr(encode(tinker_pkg::op_addi, 5'd28, 5'd0, 5'd0, 12'h400));
        put_instr(encode(tinker_pkg::op_shftli, 5'd28, 5'd0, 5'd0, 12'd3));   // Code base 0x2000
        put_instr(encode(tinker_pkg::op_addi, 5'd30, 5'd0, 5'd0, 12'h400));
        put_instr(encode(tinker_pkg::op_shftli, 5'd30, 5'd0, 5'd0, 12'd5));   // Window 0x8000
        for (int r = 0; r < 28; r++)
            put_instr(encode(tinker_pkg::op_addi, 5'(r), 5'd0, 5'd0, 12'($urandom)));
        for (int i = 0; i < 64; i++) begin
            kind = $urandom_range(0, 9);
            offs = 12'($urandom_range(0, 319) - 64);        // Negative offsets too
            if (kind < 5)
                emit_alu();
            else if (kind == 5)
                put_instr(encode(tinker_pkg::op_store, 5'd30, 5'($urandom_range(0, 31)),
                                 5'd0, offs));
            else if (kind == 6)
                put_instr(encode(tinker_pkg::op_load, 5'($urandom_range(0, 27)), 5'd30,
                                 5'd0, offs));
            else
                emit_branch();
        end
        for (int r = 0; r < 32; r++)                        // Final register dump
            put_instr(encode(tinker_pkg::op_store, 5'd30, 5'(r), 5'd0, 12'(256 + 8 * r)));
        put_instr(encode(tinker_pkg::op_halt, 5'd0, 5'd0, 5'd0, 12'd0));
    endtask

    // ----------------------------------------
    // Run control
    // ----------------------------------------
    initial begin
        reset = 1'b1;
        seed  = 80679;
        void'($urandom(seed));
        for (int a = 0; a < 65536; a++)
            mem[a] = 8'(a * 7) ^ 8'(a >> 8);                // Depends on all 16 address bits
        build_program();
        for (int a = 0; a < 65536; a++)
            i_checker.load_byte(16'(a), mem[a]);
        limit = 5 * n_instr + 40;
        fork
            begin
                repeat (limit) @(posedge clk);
                $display("timeout: hlt was not raised within %0d cycles", limit);
                $display("Test failures found");
                $finish;
            end
        join_none
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        wait (hlt === 1'b1);
        repeat (8) @(posedge clk);                          // Quiet bus after halt
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0 && check_count > 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule
